// ==== common/audio_recorder_pkg.sv ====
package audio_recorder_pkg;

  //////////////////////////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////////////////////////

  // one 8-bit pcm sample, as captured and replayed
  typedef logic [7:0] sample_t;

  // volume step handed to the codec driver
  typedef logic [4:0] volume_t;

  // record while the button is released, replay while it is held
  typedef enum logic {
    MODE_RECORD   = 1'b0,
    MODE_PLAYBACK = 1'b1
  } mode_e;

  //////////////////////////////////////////////////////////////////////
  // volume limits
  //////////////////////////////////////////////////////////////////////

  // value after reset
  localparam volume_t VOLUME_RESET = 5'd8;

  // upper end of the range, the lower end is 0
  localparam volume_t VOLUME_MAX = 5'd31;

endpackage

// ==== source/button_debounce.sv ====
`timescale 1ns/100ps

module button_debounce #(
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

  logic                   last_level;
  logic [COUNT_WIDTH-1:0] stable_count;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      // start out settled on whatever the pin shows now
      last_level   <= noisy;
      clean        <= noisy;
      stable_count <= '0;
    end
    else if (noisy != last_level)
    begin
      // input moved, wait for it to hold still again
      last_level   <= noisy;
      stable_count <= '0;
    end
    else if (stable_count == COUNT_WIDTH'(DEBOUNCE_CYCLES))
    begin
      clean <= last_level;
    end
    else
    begin
      stable_count <= stable_count + 1'b1;
    end
  end

endmodule

// ==== source/volume_control.sv ====
`timescale 1ns/100ps

module volume_control (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         up,
  input  logic                         down,
  output audio_recorder_pkg::volume_t  volume
);

  import audio_recorder_pkg::*;

  logic up_prev;
  logic down_prev;
  logic up_rise;
  logic down_rise;

  // button levels one cycle back, for edge detection
  always_ff @(posedge clock)
  begin
    up_prev   <= up;
    down_prev <= down;
  end

  assign up_rise   = up & ~up_prev;
  assign down_rise = down & ~down_prev;

  // saturating step, a press of down takes priority over up
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      volume <= VOLUME_RESET;
    end
    else if (down_rise)
    begin
      if (volume != '0)
        volume <= volume - 1'b1;
    end
    else if (up_rise)
    begin
      if (volume != VOLUME_MAX)
        volume <= volume + 1'b1;
    end
  end

endmodule

// ==== recorder/decimation_timer.sv ====
`timescale 1ns/100ps

module decimation_timer #(
  parameter int DECIMATION = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic sample_strobe,
  input  logic restart,
  output logic tick
);

  localparam int COUNT_WIDTH = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;
  localparam logic [COUNT_WIDTH-1:0] RELOAD = COUNT_WIDTH'(DECIMATION - 1);

  logic [COUNT_WIDTH-1:0] strobe_count;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      strobe_count <= RELOAD;
      tick         <= 1'b0;
    end
    else
    begin
      tick <= 1'b0;
      if (restart)
      begin
        strobe_count <= RELOAD;
      end
      else if (sample_strobe)
      begin
        // the strobe that finds zero is the one that is kept
        if (strobe_count == '0)
        begin
          strobe_count <= RELOAD;
          tick         <= 1'b1;
        end
        else
        begin
          strobe_count <= strobe_count - 1'b1;
        end
      end
    end
  end

endmodule

// ==== recorder/sample_memory.sv ====
`timescale 1ns/100ps

module sample_memory #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                         clock,
  input  logic [ADDR_WIDTH-1:0]        address,
  input  logic                         write_enable,
  input  audio_recorder_pkg::sample_t  write_data,
  output audio_recorder_pkg::sample_t  read_data
);

  import audio_recorder_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  sample_t mem [DEPTH];

  // single port, read every cycle with a registered output
  always_ff @(posedge clock)
  begin
    if (write_enable)
      mem[address] <= write_data;
    read_data <= mem[address];
  end

endmodule

// ==== recorder/record_control.sv ====
`timescale 1ns/100ps

module record_control #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         playback,
  input  logic                         tick,
  input  audio_recorder_pkg::sample_t  sample_in,
  input  audio_recorder_pkg::sample_t  read_data,
  output logic                         restart,
  output logic [ADDR_WIDTH-1:0]        address,
  output logic                         write_enable,
  output audio_recorder_pkg::sample_t  write_data,
  output audio_recorder_pkg::sample_t  sample_out,
  output audio_recorder_pkg::mode_e    mode
);

  import audio_recorder_pkg::*;

  // the top word is never written, so a full memory holds 2^n-1 samples
  localparam logic [ADDR_WIDTH-1:0] ADDR_LAST = '1;

  mode_e                 next_mode;
  logic                  mode_change;
  logic [ADDR_WIDTH-1:0] address_next;
  logic [ADDR_WIDTH-1:0] recorded_length;
  logic                  memory_full;

  assign next_mode    = playback ? MODE_PLAYBACK : MODE_RECORD;
  assign mode_change  = (next_mode != mode);
  assign address_next = address + 1'b1;
  assign memory_full  = (address == ADDR_LAST);

  //////////////////////////////////////////////////////////////////////
  // memory write port
  //////////////////////////////////////////////////////////////////////

  // store the current sample on a record tick, unless the mode is leaving
  assign write_enable = (mode == MODE_RECORD) && tick && !mode_change && !memory_full;
  assign write_data   = sample_in;

  //////////////////////////////////////////////////////////////////////
  // mode, address and length
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mode            <= MODE_RECORD;
      restart         <= 1'b0;
      address         <= '0;
      recorded_length <= '0;
    end
    else
    begin
      restart <= mode_change;
      if (mode_change)
      begin
        mode    <= next_mode;
        address <= '0;
        // the address at this point is the number of samples written
        if (next_mode == MODE_PLAYBACK)
          recorded_length <= address;
      end
      else if (tick)
      begin
        if (mode == MODE_RECORD)
        begin
          if (!memory_full)
            address <= address_next;
        end
        else if (recorded_length != '0)
        begin
          // loop back to the first sample after the last recorded one
          if (address_next == recorded_length)
            address <= '0;
          else
            address <= address_next;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output sample
  //////////////////////////////////////////////////////////////////////

  // read_data already holds the word at address when the tick arrives
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      sample_out <= '0;
    end
    else if (mode_change)
    begin
      // silence until playback produces its first sample
      sample_out <= '0;
    end
    else if (tick && (mode == MODE_PLAYBACK))
    begin
      if (recorded_length == '0)
        sample_out <= '0;
      else
        sample_out <= read_data;
    end
  end

endmodule

// ==== source/audio_recorder.sv ====
`timescale 1ns/100ps

module audio_recorder #(
  parameter int ADDR_WIDTH      = 16,
  parameter int DECIMATION      = 8,
  parameter int DEBOUNCE_CYCLES = 270000
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         sample_strobe,
  input  audio_recorder_pkg::sample_t  sample_in,
  input  logic                         playback_button,
  input  logic                         volume_up_button,
  input  logic                         volume_down_button,
  output audio_recorder_pkg::sample_t  sample_out,
  output audio_recorder_pkg::volume_t  volume,
  output audio_recorder_pkg::mode_e    mode
);

  import audio_recorder_pkg::*;

  logic                  clean_playback;
  logic                  clean_up;
  logic                  clean_down;
  logic                  tick;
  logic                  restart;
  logic [ADDR_WIDTH-1:0] address;
  logic                  write_enable;
  sample_t               write_data;
  sample_t               read_data;

  //////////////////////////////////////////////////////////////////////
  // buttons and volume
  //////////////////////////////////////////////////////////////////////

  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_playback_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (playback_button),
    .clean (clean_playback)
  );

  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_up_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (volume_up_button),
    .clean (clean_up)
  );

  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_down_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (volume_down_button),
    .clean (clean_down)
  );

  volume_control i_volume_control (
    .clock  (clock),
    .reset  (reset),
    .up     (clean_up),
    .down   (clean_down),
    .volume (volume)
  );

  //////////////////////////////////////////////////////////////////////
  // recorder
  //////////////////////////////////////////////////////////////////////

  decimation_timer #(.DECIMATION(DECIMATION)) i_decimation_timer (
    .clock         (clock),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .restart       (restart),
    .tick          (tick)
  );

  record_control #(.ADDR_WIDTH(ADDR_WIDTH)) i_record_control (
    .clock        (clock),
    .reset        (reset),
    .playback     (clean_playback),
    .tick         (tick),
    .sample_in    (sample_in),
    .read_data    (read_data),
    .restart      (restart),
    .address      (address),
    .write_enable (write_enable),
    .write_data   (write_data),
    .sample_out   (sample_out),
    .mode         (mode)
  );

  sample_memory #(.ADDR_WIDTH(ADDR_WIDTH)) i_sample_memory (
    .clock        (clock),
    .address      (address),
    .write_enable (write_enable),
    .write_data   (write_data),
    .read_data    (read_data)
  );

endmodule

// ==== sim/recorder_model.svh ====
`ifndef RECORDER_MODEL_SVH
`define RECORDER_MODEL_SVH

// samples the recorder should hold, oldest first
sample_t recorded[$];
int      strobes_since_restart;
volume_t expected_volume;
int      check_count;
int      error_count;

// a change into record mode starts a new take and reloads the strobe count
task automatic clear_recording();
  recorded.delete();
  strobes_since_restart = 0;
endtask

// every DECIMATION-th strobe is kept until the memory is full
task automatic record_strobe(input sample_t value);
  strobes_since_restart++;
  if ((strobes_since_restart % DECIMATION) == 0 && recorded.size() < CAPACITY)
    recorded.push_back(value);
endtask

// playback loops over the take, silence when nothing was kept
function automatic sample_t expected_playback(input int index);
  if (recorded.size() == 0)
    return '0;
  return recorded[index % recorded.size()];
endfunction

task automatic step_volume(input bit up);
  if (up && expected_volume != VOLUME_MAX)
    expected_volume++;
  else if (!up && expected_volume != 5'd0)
    expected_volume--;
endtask

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string message);
  check_count++;
  if (actual !== expected)
  begin
    $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, message, actual, expected);
    error_count++;
  end
endtask

`endif

// ==== sim/audio_recorder_tb.sv ====
`timescale 1ns/100ps

module audio_recorder_tb;

  import audio_recorder_pkg::*;

  localparam int ADDR_WIDTH      = 5;
  localparam int DECIMATION      = 4;
  localparam int DEBOUNCE_CYCLES = 6;
  localparam int CAPACITY        = 2 ** ADDR_WIDTH - 1;
  // the full run needs roughly 2600 cycles
  localparam int TIMEOUT_CYCLES  = 4000;
  localparam int MODE_WAIT_LIMIT = 4 * DEBOUNCE_CYCLES;
  localparam int BUTTON_UP       = 0;
  localparam int BUTTON_DOWN     = 1;
  localparam int BUTTON_PLAY     = 2;

  logic    clock = 1'b0;
  logic    reset;
  logic    sample_strobe;
  sample_t sample_in;
  logic    playback_button;
  logic    volume_up_button;
  logic    volume_down_button;
  sample_t sample_out;
  volume_t volume;
  mode_e   mode;
  integer  seed;
  int      cycle_count = 0;
  int      test_errors_start;

  `include "recorder_model.svh"

  audio_recorder #(
    .ADDR_WIDTH      (ADDR_WIDTH),
    .DECIMATION      (DECIMATION),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) i_audio_recorder (
    .clock              (clock),
    .reset              (reset),
    .sample_strobe      (sample_strobe),
    .sample_in          (sample_in),
    .playback_button    (playback_button),
    .volume_up_button   (volume_up_button),
    .volume_down_button (volume_down_button),
    .sample_out         (sample_out),
    .volume             (volume),
    .mode               (mode)
  );

  always #2 clock = ~clock;

  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_button(input int which, input logic level);
    case (which)
      BUTTON_UP:   volume_up_button   <= level;
      BUTTON_DOWN: volume_down_button <= level;
      default:     playback_button    <= level;
    endcase
  endtask

  // release is held long enough for the clean level to settle
  task automatic press_button(input int which, input int hold_cycles);
    @(posedge clock);
    drive_button(which, 1'b1);
    repeat (hold_cycles) @(posedge clock);
    drive_button(which, 1'b0);
    repeat (DEBOUNCE_CYCLES + 4) @(posedge clock);
    @(negedge clock);
  endtask

  // a short playback pulse must never reach the mode register
  task automatic watch_mode_during_pulse(input int hold_cycles);
    @(posedge clock);
    drive_button(BUTTON_PLAY, 1'b1);
    repeat (hold_cycles) @(posedge clock);
    drive_button(BUTTON_PLAY, 1'b0);
    repeat (DEBOUNCE_CYCLES + 4)
    begin
      @(negedge clock);
      check_value(mode, MODE_RECORD, "mode after a short pulse");
    end
  endtask

  // sample_in stays put until the next strobe, past the write tick
  task automatic send_strobe(input sample_t value);
    @(posedge clock);
    sample_strobe <= 1'b1;
    sample_in     <= value;
    @(posedge clock);
    sample_strobe <= 1'b0;
    repeat (2) @(posedge clock);
  endtask

  task automatic wait_for_mode(input mode_e target);
    int waited;
    waited = 0;
    @(negedge clock);
    while (mode !== target && waited < MODE_WAIT_LIMIT)
    begin
      @(negedge clock);
      waited++;
    end
    if (mode !== target)
    begin
      $display("mode did not switch to %s within %0d cycles", target.name(), MODE_WAIT_LIMIT);
      error_count++;
    end
    // let the restart pulse reload the decimation counter
    repeat (2) @(posedge clock);
  endtask

  task automatic set_playback(input logic level);
    @(posedge clock);
    playback_button <= level;
    wait_for_mode(level ? MODE_PLAYBACK : MODE_RECORD);
    if (!level)
      clear_recording();
  endtask

  task automatic record_kept(input int kept);
    sample_t value;
    repeat (kept * DECIMATION)
    begin
      value = sample_t'($random(seed));
      send_strobe(value);
      record_strobe(value);
    end
  endtask

  // each group of strobes ends in one tick, so one new output sample
  task automatic play_and_check(input int count);
    for (int i = 0; i < count; i++)
    begin
      repeat (DECIMATION) send_strobe(8'h00);
      @(negedge clock);
      check_value(sample_out, expected_playback(i), $sformatf("playback sample %0d", i));
    end
  endtask

  task automatic report_test(input string name);
    int errors;
    errors = error_count - test_errors_start;
    if (errors == 0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors);
    test_errors_start = error_count;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed              = 85;
    check_count       = 0;
    error_count       = 0;
    test_errors_start = 0;
    expected_volume   = VOLUME_RESET;
    clear_recording();
    reset              <= 1'b1;
    sample_strobe      <= 1'b0;
    sample_in          <= '0;
    playback_button    <= 1'b0;
    volume_up_button   <= 1'b0;
    volume_down_button <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);

    check_value(volume, VOLUME_RESET, "volume after reset");
    check_value(mode, MODE_RECORD, "mode after reset");
    check_value(sample_out, 0, "sample_out after reset");
    report_test("reset values");

    for (int i = 0; i < 10; i++)
    begin
      press_button(BUTTON_DOWN, 10);
      step_volume(1'b0);
      check_value(volume, expected_volume, "volume after a down press");
    end
    for (int i = 0; i < 33; i++)
    begin
      press_button(BUTTON_UP, 10);
      step_volume(1'b1);
      check_value(volume, expected_volume, "volume after an up press");
    end
    check_value(volume, VOLUME_MAX, "volume held at the top");
    report_test("volume steps");

    // at the top a leaked down pulse would show as a lower volume
    press_button(BUTTON_DOWN, 3);
    check_value(volume, expected_volume, "volume after a short pulse");
    watch_mode_during_pulse(3);
    report_test("short pulses");

    record_kept(10);
    set_playback(1'b1);
    play_and_check(12);
    report_test("record and loop");

    set_playback(1'b0);
    record_kept(40);
    set_playback(1'b1);
    play_and_check(CAPACITY + 1);
    report_test("record past capacity");

    // no strobes while in record mode, so the take is empty
    set_playback(1'b0);
    set_playback(1'b1);
    play_and_check(3);
    report_test("empty recording");

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+sim
common/audio_recorder_pkg.sv
source/button_debounce.sv
source/volume_control.sv
recorder/decimation_timer.sv
recorder/sample_memory.sv
recorder/record_control.sv
source/audio_recorder.sv
sim/audio_recorder_tb.sv

// ==== Bender.yml ====
package:
  name: audio_recorder

sources:
  - files:
      - common/audio_recorder_pkg.sv
      - source/button_debounce.sv
      - source/volume_control.sv
      - recorder/decimation_timer.sv
      - recorder/sample_memory.sv
      - recorder/record_control.sv
      - source/audio_recorder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/audio_recorder_tb.sv
